// File: include/wl_params.svh
// weight-load path sizing
// atom geometry, MAC cell count, store depth and decoder pipeline depth

`ifndef WL_PARAMS_SVH
`define WL_PARAMS_SVH

// bytes per atom
`define WL_ATOMC 8

// bits per byte, int8 only
`define WL_BPE 8

// MAC cells the select rotates over
`define WL_ATOMK 4

// words in the weight store
`define WL_STORE_DEPTH 64

// data_load to weight_valid, in cycles
`define WL_DEC_LAT 3

`endif

// File: design/wl_pkg.sv
// weight-load types
// header view of a store word, the two-way store word union and
// the sequencer state encoding

`include "wl_params.svh"

package wl_pkg;

  // header word layout, lsb first
  //   mask        [7:0]   set bit = byte is nonzero
  //   atom_count  [11:8]  data words that follow, 1 to 15
  //   compressed  [12]    clear = mask taken as all ones
  typedef struct packed {
    logic [`WL_ATOMC*`WL_BPE-`WL_ATOMC-6:0] unused;
    logic                                    compressed;
    logic [3:0]                              atom_count;
    logic [`WL_ATOMC-1:0]                    mask;
  } wl_hdr_t;

  // one store word, decoded as a header or as packed bytes
  // byte 0 holds the first nonzero byte of the atom
  typedef union packed {
    wl_hdr_t                           hdr;
    logic [`WL_ATOMC-1:0][`WL_BPE-1:0] bytes;
  } wl_word_u;

  // job sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    HDR   = 2'd1,
    DATA  = 2'd2,
    DRAIN = 2'd3
  } wl_state_e;

endpackage

// File: design/wl_weight_store.sv
// weight store
// single write port, single read port memory of store words
// read data is registered and follows rd_en by one cycle

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_weight_store (
  input  logic                               nvdla_core_clk,
  input  logic                               wr_en,
  input  logic [$clog2(`WL_STORE_DEPTH)-1:0] wr_addr,
  input  wl_pkg::wl_word_u                   wr_data,
  input  logic                               rd_en,
  input  logic [$clog2(`WL_STORE_DEPTH)-1:0] rd_addr,
  output wl_pkg::wl_word_u                   rd_data
);

  // headers and packed atoms, interleaved per group
  wl_pkg::wl_word_u mem [`WL_STORE_DEPTH];

  // write side, any cycle with wr_en
  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read side
  // output holds its last word while rd_en is low
  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: design/wl_seq_counter.sv
// sequencer counters
// groups left in the job, atoms left in the current group and the
// one-hot MAC cell select that rotates once per atom

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_seq_counter (
  input  logic                 nvdla_core_clk,
  input  logic                 reset,
  input  logic                 grp_load,
  input  logic [7:0]           num_groups,
  input  logic                 grp_step,
  input  logic                 cnt_load,
  input  logic [3:0]           atom_count,
  input  logic                 atom_step,
  input  logic                 start,
  output logic                 last_group,
  output logic                 last_atom,
  output logic [`WL_ATOMK-1:0] sel
);

  localparam logic [`WL_ATOMK-1:0] CELL0 = `WL_ATOMK'(1);

  logic [7:0] grp_cnt;
  logic [7:0] grp_eff;
  logic [3:0] atom_cnt;
  logic [3:0] atom_eff;
  logic       step_q;

  // a load and a step may share a cycle
  // the loaded value then counts as already present
  assign grp_eff  = grp_load ? num_groups : grp_cnt;
  assign atom_eff = cnt_load ? atom_count : atom_cnt;

  // flags describe the item being stepped this cycle
  assign last_group = (grp_eff == 8'd1);
  assign last_atom  = (atom_eff == 4'd1);

  ////////////////////////////////////////////////////////////////////////////
  // down-counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      grp_cnt  <= '0;
      atom_cnt <= '0;
    end else begin
      if (grp_load || grp_step) begin
        grp_cnt <= grp_eff - 8'(grp_step);
      end
      if (cnt_load || atom_step) begin
        atom_cnt <= atom_eff - 4'(atom_step);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // cell select
  ////////////////////////////////////////////////////////////////////////////
  // atom_step marks the store read, step_q lands with the decoder's data_load
  // so sel still names the cell of the atom being loaded
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      step_q <= 1'b0;
      sel    <= CELL0;
    end else begin
      step_q <= atom_step;
      if (start) begin
        sel <= CELL0;
      end else if (step_q) begin
        sel <= {sel[`WL_ATOMK-2:0], sel[`WL_ATOMK-1]};
      end
    end
  end

  a_sel_onehot: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    $onehot(sel))
    else $error("cell select not one-hot: %b", sel);

endmodule

// File: design/wl_seq_fsm.sv
// job sequencer
// walks num_groups groups from base_addr: one header read then
// atom_count data reads per group, no gaps, then drains the decoder
// load strobes are aligned to the store's one-cycle read latency

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_seq_fsm (
  input  logic                               nvdla_core_clk,
  input  logic                               reset,
  input  logic                               start,
  input  logic [$clog2(`WL_STORE_DEPTH)-1:0] base_addr,
  input  wl_pkg::wl_word_u                   rd_data,
  input  logic                               last_group,
  input  logic                               last_atom,
  output logic                               rd_en,
  output logic [$clog2(`WL_STORE_DEPTH)-1:0] rd_addr,
  output logic                               hdr_load,
  output logic                               data_load,
  output logic                               grp_load,
  output logic                               cnt_load,
  output logic [3:0]                         atom_count,
  output logic                               grp_step,
  output logic                               atom_step,
  output logic                               busy,
  output logic                               done
);

  localparam int DRAIN_W = $clog2(`WL_DEC_LAT + 1);

  wl_pkg::wl_state_e                  state;
  wl_pkg::wl_state_e                  state_nxt;
  logic [$clog2(`WL_STORE_DEPTH)-1:0] addr_q;
  logic [DRAIN_W-1:0]                 drain_cnt;
  logic                               hdr_kind_q;
  logic                               data_kind_q;
  logic                               grp_end;

  // reads go out in HDR and DATA, one word per cycle
  assign rd_en     = (state == wl_pkg::HDR) || (state == wl_pkg::DATA);
  assign rd_addr   = addr_q;
  assign atom_step = (state == wl_pkg::DATA);
  assign busy      = (state != wl_pkg::IDLE);

  // read kind, one cycle late, lines up with rd_data
  assign hdr_load  = hdr_kind_q;
  assign data_load = data_kind_q;

  // header returns during the group's first data read
  // its atom count goes straight into the counter
  assign cnt_load   = hdr_kind_q;
  assign atom_count = rd_data.hdr.atom_count;

  assign grp_load = (state == wl_pkg::IDLE) && start;
  assign grp_end  = atom_step && last_atom;
  assign grp_step = grp_end;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      wl_pkg::IDLE: begin
        if (start) begin
          state_nxt = wl_pkg::HDR;
        end
      end
      wl_pkg::HDR: begin
        state_nxt = wl_pkg::DATA;
      end
      wl_pkg::DATA: begin
        // next header read follows the last data read directly
        if (grp_end) begin
          state_nxt = last_group ? wl_pkg::DRAIN : wl_pkg::HDR;
        end
      end
      wl_pkg::DRAIN: begin
        // WL_DEC_LAT+1 cycles, last atom out of the decoder by then
        if (drain_cnt == DRAIN_W'(`WL_DEC_LAT)) begin
          state_nxt = wl_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = wl_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state, kind and drain registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      state       <= wl_pkg::IDLE;
      hdr_kind_q  <= 1'b0;
      data_kind_q <= 1'b0;
      drain_cnt   <= '0;
      done        <= 1'b0;
    end else begin
      state       <= state_nxt;
      hdr_kind_q  <= (state == wl_pkg::HDR);
      data_kind_q <= (state == wl_pkg::DATA);
      // done pulses in the first IDLE cycle, same cycle busy drops
      done        <= (state == wl_pkg::DRAIN) && (state_nxt == wl_pkg::IDLE);
      if (state == wl_pkg::DRAIN) begin
        drain_cnt <= drain_cnt + DRAIN_W'(1);
      end else begin
        drain_cnt <= '0;
      end
    end
  end

  // read address, loaded on start and bumped per read
  always_ff @(posedge nvdla_core_clk) begin
    if (grp_load) begin
      addr_q <= base_addr;
    end else if (rd_en) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  a_no_start_busy: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    !(start && busy))
    else $error("start while busy, state %s", state.name());

  a_load_excl: assert property (@(posedge nvdla_core_clk) disable iff (reset)
    !(hdr_load && data_load))
    else $error("header and data load in the same cycle");

endmodule

// File: design/wl_dec.sv
// weight decompressor, int8
// expands packed nonzero bytes into a full atom using the group's
// sparsity mask: prefix sums, byte mux, nonzero mask
// three cycles from data_load to weight_valid, fully pipelined

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_dec (
  input  logic                          nvdla_core_clk,
  input  logic                          reset,
  input  logic                          hdr_load,
  input  logic                          data_load,
  input  wl_pkg::wl_word_u              word,
  input  logic [`WL_ATOMK-1:0]          sel,
  output logic                          weight_valid,
  output logic [`WL_ATOMC*`WL_BPE-1:0]  weight_data,
  output logic [`WL_ATOMC-1:0]          weight_mask,
  output logic [`WL_ATOMK-1:0]          weight_sel
);

  // prefix sums run 0..ATOMC, mux index 0..ATOMC-1
  localparam int SUM_W = $clog2(`WL_ATOMC + 1);
  localparam int IDX_W = $clog2(`WL_ATOMC);
  localparam logic [`WL_ATOMK-1:0] CELL0 = `WL_ATOMK'(1);

  wl_pkg::wl_hdr_t                   hdr;
  logic [`WL_ATOMC-1:0]              mask_g;
  logic [SUM_W-1:0]                  sum_d [`WL_ATOMC];
  logic [SUM_W-1:0]                  sum_q [`WL_ATOMC];
  logic [`WL_ATOMC-1:0]              mask_q;
  logic [IDX_W-1:0]                  pick_idx [`WL_ATOMC];
  logic [`WL_ATOMC-1:0][`WL_BPE-1:0] data_d1;
  logic [`WL_ATOMC-1:0][`WL_BPE-1:0] mux_byte;
  logic [`WL_ATOMC-1:0][`WL_BPE-1:0] data_d2;
  logic [`WL_ATOMC-1:0][`WL_BPE-1:0] data_d3;
  logic [`WL_ATOMC-1:0]              nz_mask;
  logic [`WL_ATOMC-1:0]              mask_d3;
  logic [`WL_ATOMK-1:0]              sel_d1;
  logic [`WL_ATOMK-1:0]              sel_d2;
  logic [`WL_ATOMK-1:0]              sel_d3;
  logic                              valid_d1;
  logic                              valid_d2;
  logic                              valid_d3;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: prefix sums of the header mask
  ////////////////////////////////////////////////////////////////////////////
  assign hdr = word.hdr;

  // uncompressed group, every byte present, data passes through
  assign mask_g = hdr.compressed ? hdr.mask : '1;

  // sum_d[i] = set mask bits in 0..i, so byte i takes packed byte sum-1
  always_comb begin
    logic [SUM_W-1:0] run;
    run = '0;
    for (int i = 0; i < `WL_ATOMC; i++) begin
      run      = run + SUM_W'(mask_g[i]);
      sum_d[i] = run;
    end
  end

  // header state stays until the next group's header
  // one header serves all atom_count atoms
  always_ff @(posedge nvdla_core_clk) begin
    if (hdr_load) begin
      sum_q  <= sum_d;
      mask_q <= mask_g;
    end
    if (data_load) begin
      data_d1 <= word.bytes;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2: byte mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `WL_ATOMC; i++) begin
      pick_idx[i] = IDX_W'(sum_q[i] - SUM_W'(1));
      case (sum_q[i]) inside
        [1:`WL_ATOMC]: mux_byte[i] = data_d1[pick_idx[i]];
        default:       mux_byte[i] = '0;
      endcase
      // masked-off byte would repeat its left neighbour's pick
      mux_byte[i] = mux_byte[i] & {`WL_BPE{mask_q[i]}};
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (valid_d1) begin
      data_d2 <= mux_byte;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 3: nonzero mask
  ////////////////////////////////////////////////////////////////////////////
  // a zero byte inside the packed data clears its bit too
  always_comb begin
    for (int i = 0; i < `WL_ATOMC; i++) begin
      nz_mask[i] = |data_d2[i];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (valid_d2) begin
      data_d3 <= data_d2;
      mask_d3 <= nz_mask;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // valid and cell select pipe
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk) begin
    if (reset) begin
      valid_d1 <= 1'b0;
      valid_d2 <= 1'b0;
      valid_d3 <= 1'b0;
      sel_d1   <= CELL0;
      sel_d2   <= CELL0;
      sel_d3   <= CELL0;
    end else begin
      valid_d1 <= data_load;
      valid_d2 <= valid_d1;
      valid_d3 <= valid_d2;
      if (data_load) begin
        sel_d1 <= sel;
      end
      if (valid_d1) begin
        sel_d2 <= sel_d1;
      end
      if (valid_d2) begin
        sel_d3 <= sel_d2;
      end
    end
  end

  // outputs
  assign weight_valid = valid_d3;
  assign weight_data  = data_d3;
  assign weight_mask  = mask_d3;
  assign weight_sel   = sel_d3;

endmodule

// File: design/wl_top.sv
// weight-load subsystem
// store, job sequencer, sequencer counters and decompressor
// start runs num_groups groups from base_addr; done ends the job

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_top (
  input  logic                               nvdla_core_clk,
  input  logic                               reset,
  // store write port
  input  logic                               wr_en,
  input  logic [$clog2(`WL_STORE_DEPTH)-1:0] wr_addr,
  input  wl_pkg::wl_word_u                   wr_data,
  // job port
  input  logic                               start,
  input  logic [$clog2(`WL_STORE_DEPTH)-1:0] base_addr,
  input  logic [7:0]                         num_groups,
  output logic                               busy,
  output logic                               done,
  // expanded atoms
  output logic                               weight_valid,
  output logic [`WL_ATOMC*`WL_BPE-1:0]       weight_data,
  output logic [`WL_ATOMC-1:0]               weight_mask,
  output logic [`WL_ATOMK-1:0]               weight_sel
);

  logic                               rd_en;
  logic [$clog2(`WL_STORE_DEPTH)-1:0] rd_addr;
  wl_pkg::wl_word_u                   rd_data;
  logic                               hdr_load;
  logic                               data_load;
  logic                               grp_load;
  logic                               cnt_load;
  logic [3:0]                         atom_count;
  logic                               grp_step;
  logic                               atom_step;
  logic                               last_group;
  logic                               last_atom;
  logic [`WL_ATOMK-1:0]               sel;

  wl_weight_store u_store (
    .nvdla_core_clk (nvdla_core_clk),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data)
  );

  wl_seq_fsm u_fsm (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .start          (start),
    .base_addr      (base_addr),
    .rd_data        (rd_data),
    .last_group     (last_group),
    .last_atom      (last_atom),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .hdr_load       (hdr_load),
    .data_load      (data_load),
    .grp_load       (grp_load),
    .cnt_load       (cnt_load),
    .atom_count     (atom_count),
    .grp_step       (grp_step),
    .atom_step      (atom_step),
    .busy           (busy),
    .done           (done)
  );

  wl_seq_counter u_cnt (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .grp_load       (grp_load),
    .num_groups     (num_groups),
    .grp_step       (grp_step),
    .cnt_load       (cnt_load),
    .atom_count     (atom_count),
    .atom_step      (atom_step),
    .start          (start),
    .last_group     (last_group),
    .last_atom      (last_atom),
    .sel            (sel)
  );

  // decoder sees every store word, the strobes say which kind
  wl_dec u_dec (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .hdr_load       (hdr_load),
    .data_load      (data_load),
    .word           (rd_data),
    .sel            (sel),
    .weight_valid   (weight_valid),
    .weight_data    (weight_data),
    .weight_mask    (weight_mask),
    .weight_sel     (weight_sel)
  );

endmodule

// File: tests/wl_tb.sv
// weight-load path testbench
// loads groups through the store write port, runs jobs and checks each
// expanded atom, its nonzero mask and its cell select against a
// software model of the decompressor

`timescale 1ns/1ns

`include "wl_params.svh"

module wl_tb;

  localparam int AW            = $clog2(`WL_STORE_DEPTH);
  localparam int GRP_WORDS_MAX = 16;

  // worst case for one job is two cycles per store write and one per read
  // plus start, drain and done
  function automatic int job_budget(input int grps);
    return 3 * GRP_WORDS_MAX * grps + `WL_DEC_LAT + 8;
  endfunction

  localparam int CYCLE_LIMIT = 2 * (job_budget(2) + job_budget(3) + job_budget(1) +
                                    job_budget(3) + job_budget(2) + job_budget(2) + 8);

  logic                         nvdla_core_clk;
  logic                         reset;
  logic                         wr_en;
  logic [AW-1:0]                wr_addr;
  wl_pkg::wl_word_u             wr_data;
  logic                         start;
  logic [AW-1:0]                base_addr;
  logic [7:0]                   num_groups;
  logic                         busy;
  logic                         done;
  logic                         weight_valid;
  logic [`WL_ATOMC*`WL_BPE-1:0] weight_data;
  logic [`WL_ATOMC-1:0]         weight_mask;
  logic [`WL_ATOMK-1:0]         weight_sel;

  // expected atoms of the running job in order
  wl_pkg::wl_word_u     exp_data_q [$];
  logic [`WL_ATOMC-1:0] exp_mask_q [$];
  logic [`WL_ATOMK-1:0] exp_sel_q  [$];

  integer        seed;
  int            errors;
  int            tests;
  int            total_atoms;
  int            atoms_seen;
  int            job_atoms;
  int            groups;
  int            test_err0;
  int            cycles;
  bit            in_job;
  logic [AW-1:0] wptr;
  logic [AW-1:0] job_base;

  wl_top DUT (
    .nvdla_core_clk (nvdla_core_clk),
    .reset          (reset),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .start          (start),
    .base_addr      (base_addr),
    .num_groups     (num_groups),
    .busy           (busy),
    .done           (done),
    .weight_valid   (weight_valid),
    .weight_data    (weight_data),
    .weight_mask    (weight_mask),
    .weight_sel     (weight_sel)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  // packed bytes fill the set mask positions from byte 0 upward
  // an uncompressed header sets every position
  function automatic wl_pkg::wl_word_u wl_expand(input wl_pkg::wl_hdr_t hdr,
                                                 input wl_pkg::wl_word_u pw);
    wl_pkg::wl_word_u     res;
    logic [`WL_ATOMC-1:0] m;
    int                   nxt;
    res = '0;
    m   = hdr.compressed ? hdr.mask : '1;
    nxt = 0;
    for (int i = 0; i < `WL_ATOMC; i++) begin
      if (m[i]) begin
        res.bytes[i] = pw.bytes[nxt];
        nxt++;
      end
    end
    return res;
  endfunction

  function automatic logic [`WL_ATOMC-1:0] nonzero_bytes(input wl_pkg::wl_word_u w);
    logic [`WL_ATOMC-1:0] nz;
    for (int i = 0; i < `WL_ATOMC; i++) begin
      nz[i] = (w.bytes[i] != '0);
    end
    return nz;
  endfunction

  // roughly one byte in eight is forced to zero when zeros are allowed
  function automatic logic [`WL_BPE-1:0] rand_byte(input bit zeros);
    logic [31:0] r;
    r = $random(seed);
    if (zeros && r[10:8] == 3'd0) begin
      return '0;
    end
    return (r[7:0] == 8'h00) ? 8'h5a : r[7:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_data(input wl_pkg::wl_word_u got, input wl_pkg::wl_word_u exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t weight_data got %h expected %h", $time, got.bytes, exp.bytes);
    end
  endtask

  task automatic check_mask(input logic [`WL_ATOMC-1:0] got,
                            input logic [`WL_ATOMC-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t weight_mask got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_sel(input logic [`WL_ATOMK-1:0] got,
                           input logic [`WL_ATOMK-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t weight_sel got %b expected %b", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // store loading and jobs
  ////////////////////////////////////////////////////////////////////////////
  task automatic write_word(input logic [AW-1:0] a, input wl_pkg::wl_word_u d);
    @(posedge nvdla_core_clk);
    wr_en   <= 1'b1;
    wr_addr <= a;
    wr_data <= d;
    @(posedge nvdla_core_clk);
    wr_en   <= 1'b0;
  endtask

  task automatic new_job(input logic [AW-1:0] base);
    job_base  = base;
    wptr      = base;
    job_atoms = 0;
    groups    = 0;
    test_err0 = errors;
  endtask

  // header then count packed words with expected atoms queued in order
  task automatic add_group(input logic comp, input logic [`WL_ATOMC-1:0] mask,
                           input int count, input bit zeros);
    wl_pkg::wl_word_u h;
    wl_pkg::wl_word_u d;
    wl_pkg::wl_word_u e;
    h                = '0;
    h.hdr.mask       = mask;
    h.hdr.compressed = comp;
    h.hdr.atom_count = 4'(count);
    write_word(wptr, h);
    wptr++;
    for (int a = 0; a < count; a++) begin
      for (int b = 0; b < `WL_ATOMC; b++) begin
        d.bytes[b] = rand_byte(zeros);
      end
      write_word(wptr, d);
      wptr++;
      e = wl_expand(h.hdr, d);
      exp_data_q.push_back(e);
      exp_mask_q.push_back(nonzero_bytes(e));
      // cell select runs on across groups of one job
      exp_sel_q.push_back(`WL_ATOMK'(1) << (job_atoms % `WL_ATOMK));
      job_atoms++;
    end
    groups++;
  endtask

  task automatic launch_job();
    atoms_seen = 0;
    @(posedge nvdla_core_clk);
    start      <= 1'b1;
    base_addr  <= job_base;
    num_groups <= 8'(groups);
    @(posedge nvdla_core_clk);
    start      <= 1'b0;
    in_job     = 1'b1;
  endtask

  task automatic finish_job(input string name);
    do @(negedge nvdla_core_clk); while (!done);
    in_job = 1'b0;
    if (busy) begin
      errors++;
      $display("busy still high in the done cycle at %0t", $time);
    end
    if (atoms_seen != job_atoms) begin
      errors++;
      $display("job %s gave %0d atoms before done, %0d expected", name, atoms_seen,
               job_atoms);
    end
    @(negedge nvdla_core_clk);
    if (done) begin
      errors++;
      $display("done high for more than one cycle at %0t", $time);
    end
    tests++;
    $display("test %s groups %0d atoms %0d %s", name, groups, job_atoms,
             (errors == test_err0) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process sampling on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  initial begin : compare_atoms
    wl_pkg::wl_word_u  got;
    wl_pkg::wl_state_e st;
    forever begin
      @(negedge nvdla_core_clk);
      if (!reset) begin
        if (in_job && !done && !busy) begin
          st = DUT.u_fsm.state;
          errors++;
          $display("busy low during a job at %0t, state %s", $time, st.name());
        end
        if (weight_valid) begin
          if (done) begin
            errors++;
            $display("atom in the done cycle at %0t", $time);
          end
          if (exp_data_q.size() == 0) begin
            errors++;
            $display("atom at %0t with nothing expected", $time);
          end else begin
            got = weight_data;
            check_data(got, exp_data_q.pop_front());
            check_mask(weight_mask, exp_mask_q.pop_front());
            check_sel(weight_sel, exp_sel_q.pop_front());
            atoms_seen++;
            total_atoms++;
          end
        end
      end
    end
  end

  // run limit
  initial begin : watchdog
    cycles = 0;
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge nvdla_core_clk);
      cycles++;
    end
    $display("timeout, run still going after %0d cycles", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin : main
    seed        = 32'h29a1_b15c;
    errors      = 0;
    tests       = 0;
    total_atoms = 0;
    atoms_seen  = 0;
    in_job      = 1'b0;
    reset       = 1'b1;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    start       = 1'b0;
    base_addr   = '0;
    num_groups  = '0;
    repeat (2) @(posedge nvdla_core_clk);
    reset <= 1'b0;

    // uncompressed groups ignore the header mask
    new_job(6'd0);
    add_group(1'b0, 8'(seed), 3, 1'b1);
    add_group(1'b0, 8'h0f, 2, 1'b1);
    launch_job();
    finish_job("uncompressed");

    // compressed groups with random masks and counts
    new_job(6'd8);
    for (int g = 0; g < 3; g++) begin
      add_group(1'b1, 8'($random(seed)), 1 + ($unsigned($random(seed)) % 15), 1'b1);
    end
    launch_job();
    finish_job("compressed");

    // one header serving six atoms without zero bytes
    // so every mask equals the header's
    new_job(6'd20);
    add_group(1'b1, 8'hb5, 6, 1'b0);
    launch_job();
    finish_job("shared_header");

    // nine atoms so the select wraps twice across group borders
    new_job(6'd40);
    add_group(1'b1, 8'h3c, 3, 1'b0);
    add_group(1'b0, 8'h00, 2, 1'b0);
    add_group(1'b1, 8'h81, 4, 1'b1);
    launch_job();
    finish_job("sel_rotate");

    // reset while atoms are still in flight
    new_job(6'd0);
    add_group(1'b1, 8'h6d, 10, 1'b1);
    add_group(1'b0, 8'h00, 10, 1'b1);
    launch_job();
    while (atoms_seen < 3) @(posedge nvdla_core_clk);
    @(posedge nvdla_core_clk);
    reset <= 1'b1;
    @(posedge nvdla_core_clk);
    in_job = 1'b0;
    @(negedge nvdla_core_clk);
    if (busy || weight_valid) begin
      errors++;
      $display("reset left busy %b weight_valid %b at %0t", busy, weight_valid, $time);
    end
    exp_data_q.delete();
    exp_mask_q.delete();
    exp_sel_q.delete();
    @(posedge nvdla_core_clk);
    reset <= 1'b0;
    tests++;
    $display("test %s atoms before reset %0d %s", "reset_mid_job", atoms_seen,
             (errors == test_err0) ? "ok" : "failed");

    // next job after the reset
    new_job(6'd4);
    add_group(1'b1, 8'($random(seed)), 1 + ($unsigned($random(seed)) % 15), 1'b1);
    add_group(1'b1, 8'hf0, 5, 1'b1);
    launch_job();
    finish_job("after_reset");

    repeat (2) @(posedge nvdla_core_clk);
    $display("tests %0d atoms checked %0d errors %0d", tests, total_atoms, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
design/wl_pkg.sv
design/wl_weight_store.sv
design/wl_seq_counter.sv
design/wl_seq_fsm.sv
design/wl_dec.sv
design/wl_top.sv
tests/wl_tb.sv

// File: Makefile
# Verilator build for the weight-load path testbench

TOP = wl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "NO ERRORS" sim.log || { echo "no result in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
